// File: pcs_rf_top.f
logic/pcs_rf_pkg.sv
logic/rf_apb_slave.sv
logic/sh_breaker_lane.sv
logic/rf_read_mux.sv
logic/pcs_rf_top.sv
verif/pcs_rf_top_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --top-module pcs_rf_top_tb -f pcs_rf_top.f -o pcs_rf_sim

sim_out=$(./obj_dir/pcs_rf_sim 2>&1) || true
echo "$sim_out"

if grep -q "Regression passed" <<< "$sim_out"; then
    exit 0
else
    exit 1
fi

// File: verif/pcs_rf_top_tb.sv
`timescale 1ns/1ps

module pcs_rf_top_tb;

    localparam int CLK_PERIOD_NS = 8;
    localparam int SAMPLE_NS     = 2;
    localparam int MAX_WAITS     = 16;
    localparam int N_ROWS        = 8;
    localparam int CONT_SPACING  = 100;

    logic               clock;
    logic               arst_n;
    logic               psel;
    logic               penable;
    logic               pwrite;
    pcs_rf_pkg::addr_t  paddr;
    pcs_rf_pkg::data_t  pwdata;
    pcs_rf_pkg::data_t  prdata;
    logic               pready;
    logic               pslverr;

    string              row_name   [N_ROWS];
    int                 row_lane   [N_ROWS];
    int                 row_mode   [N_ROWS];
    int                 row_burst  [N_ROWS];
    int                 row_period [N_ROWS];
    int                 row_repeat [N_ROWS];

    pcs_rf_pkg::data_t  cfg_shadow [pcs_rf_pkg::N_LANES];
    pcs_rf_pkg::data_t  ctrl_shadow;
    int                 lane_order [pcs_rf_pkg::N_LANES];
    int                 watchdog_ns;
    logic               table_ready;

    pcs_rf_top pcs_rf_top_i (
        .i_clock   (clock),
        .i_arst_n  (arst_n),
        .i_psel    (psel),
        .i_penable (penable),
        .i_pwrite  (pwrite),
        .i_paddr   (paddr),
        .i_pwdata  (pwdata),
        .o_prdata  (prdata),
        .o_pready  (pready),
        .o_pslverr (pslverr)
    );

    initial begin
        clock = 1'b0;
        forever begin
            #(CLK_PERIOD_NS / 2) clock = ~clock;
        end
    end

    task automatic stop_on_error(input string reason);
        $display("%s", reason);
        $display("Regression failed");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_value(input string name, input int expected, input int actual);
        assert (actual == expected) else begin
            stop_on_error($sformatf("FAILED %s: expected 0x%0h, actual 0x%0h",
                                    name, expected, actual));
        end
    endtask

    task automatic check_nonzero(input string name, input int actual);
        assert (actual != 0) else begin
            stop_on_error($sformatf("FAILED %s: expected nonzero, actual 0x%0h", name, actual));
        end
    endtask

    task automatic set_row(input int idx, input string name, input int lane, input int mode,
                           input int burst, input int period, input int rpt);
        row_name[idx]   = name;
        row_lane[idx]   = lane;
        row_mode[idx]   = mode;
        row_burst[idx]  = burst;
        row_period[idx] = period;
        row_repeat[idx] = rpt;
    endtask

    // Rows 0..3 cover lanes 0..3 in order, reused for the independence phase
    task automatic load_table();
        set_row(0, "fixed_l0",          0, 1,  5, 20,  3);
        set_row(1, "fixed_l1",          1, 1, 12, 40,  2);
        set_row(2, "fixed_clip_l2",     2, 1, 50, 30,  4);
        set_row(3, "fixed_l3",          3, 1,  1,  8, 15);
        set_row(4, "cont_full_l1",      1, 2, 16, 16,  0);
        set_row(5, "cont_l3",           3, 2, 10, 50,  0);
        set_row(6, "off_l0",            0, 0,  7, 20,  2);
        set_row(7, "fixed_zero_rep_l2", 2, 1,  9, 20,  0);
    endtask

    function automatic int expected_errors(input int idx);
        int clip;
        clip = (row_burst[idx] > row_period[idx]) ? row_period[idx] : row_burst[idx];
        if (row_mode[idx] == 1) begin
            return clip * row_repeat[idx];
        end
        return 0;
    endfunction

    function automatic int row_wait(input int idx);
        return row_period[idx] * (row_repeat[idx] + 1) + 200;
    endfunction

    function automatic pcs_rf_pkg::data_t cfg_word(input int mode, input int rpt,
                                                   input int burst, input int period);
        pcs_rf_pkg::data_t word;
        word = '0;
        word[pcs_rf_pkg::CFG_MODE_LSB +: pcs_rf_pkg::NB_MODE] = pcs_rf_pkg::mode_t'(mode);
        word[pcs_rf_pkg::CFG_REPEAT_LSB +: pcs_rf_pkg::NB_REPEAT_CNT] = pcs_rf_pkg::repeat_t'(rpt);
        word[pcs_rf_pkg::CFG_BURST_LSB +: pcs_rf_pkg::NB_BURST_CNT] = pcs_rf_pkg::burst_t'(burst);
        word[pcs_rf_pkg::CFG_PERIOD_LSB +: pcs_rf_pkg::NB_PERIOD_CNT] =
            pcs_rf_pkg::period_t'(period);
        return word;
    endfunction

    function automatic pcs_rf_pkg::addr_t lane_addr(input int lane,
                                                     input pcs_rf_pkg::addr_t offset);
        return pcs_rf_pkg::addr_t'(int'(pcs_rf_pkg::ADDR_LANE_BASE) +
                                   lane * int'(pcs_rf_pkg::LANE_STRIDE) + int'(offset));
    endfunction

    // Setup on one falling edge, access on the next, sampled mid-cycle
    task automatic apb_transfer(input logic write, input pcs_rf_pkg::addr_t addr,
                                input pcs_rf_pkg::data_t wdata,
                                output pcs_rf_pkg::data_t rdata, output logic slverr);
        int waits;
        @(negedge clock);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = write;
        paddr   = addr;
        pwdata  = wdata;
        @(negedge clock);
        penable = 1'b1;
        waits   = 0;
        #(SAMPLE_NS);
        while (!pready) begin
            @(negedge clock);
            #(SAMPLE_NS);
            waits++;
            assert (waits <= MAX_WAITS) else begin
                stop_on_error($sformatf("pready never rose for the access to address 0x%0h",
                                        addr));
            end
        end
        // Writes complete at once, reads after one wait state
        check_value($sformatf("wait states at 0x%0h", addr), write ? 0 : 1, waits);
        rdata  = prdata;
        slverr = pslverr;
        @(negedge clock);
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        repeat (int'($urandom_range(0, 2))) @(negedge clock);
    endtask

    task automatic write_reg(input pcs_rf_pkg::addr_t addr, input pcs_rf_pkg::data_t data);
        pcs_rf_pkg::data_t unused;
        logic              slverr;
        apb_transfer(1'b1, addr, data, unused, slverr);
        check_value($sformatf("pslverr on write to 0x%0h", addr), 0, int'(slverr));
    endtask

    task automatic read_reg(input pcs_rf_pkg::addr_t addr, output pcs_rf_pkg::data_t data);
        logic slverr;
        apb_transfer(1'b0, addr, '0, data, slverr);
        check_value($sformatf("pslverr on read of 0x%0h", addr), 0, int'(slverr));
    endtask

    task automatic write_ctrl(input pcs_rf_pkg::data_t data);
        write_reg(pcs_rf_pkg::ADDR_CTRL, data);
        ctrl_shadow = data;
    endtask

    task automatic write_cfg(input int lane, input pcs_rf_pkg::data_t data);
        write_reg(lane_addr(lane, pcs_rf_pkg::CFG_OFFSET), data);
        cfg_shadow[lane] = data;
    endtask

    task automatic read_status(input int lane, output int cnt, output int lock);
        pcs_rf_pkg::data_t word;
        read_reg(lane_addr(lane, pcs_rf_pkg::STATUS_OFFSET), word);
        cnt  = int'(word[pcs_rf_pkg::STATUS_ERR_LSB +: pcs_rf_pkg::NB_ERR_CNT]);
        lock = int'(word[pcs_rf_pkg::STATUS_LOCK_BIT]);
    endtask

    // Lane off, pipeline drained, counter cleared by a read
    task automatic clear_lane(input int lane);
        int cnt;
        int lock;
        write_cfg(lane, '0);
        repeat (4) @(negedge clock);
        read_status(lane, cnt, lock);
    endtask

    task automatic check_registers(input string name);
        pcs_rf_pkg::data_t word;
        read_reg(pcs_rf_pkg::ADDR_CTRL, word);
        check_value($sformatf("%s ctrl", name), int'(ctrl_shadow), int'(word));
        for (int lane = 0; lane < pcs_rf_pkg::N_LANES; lane++) begin
            read_reg(lane_addr(lane, pcs_rf_pkg::CFG_OFFSET), word);
            check_value($sformatf("%s cfg lane %0d", name, lane),
                        int'(cfg_shadow[lane]), int'(word));
        end
    endtask

    task automatic shuffle_lane_order();
        int j;
        int tmp;
        for (int i = 0; i < pcs_rf_pkg::N_LANES; i++) begin
            lane_order[i] = i;
        end
        for (int i = pcs_rf_pkg::N_LANES - 1; i > 0; i--) begin
            j = int'($urandom_range(0, i));
            tmp = lane_order[i];
            lane_order[i] = lane_order[j];
            lane_order[j] = tmp;
        end
    endtask

    task automatic run_row(input int idx);
        int lane;
        int cnt;
        int lock;
        lane = row_lane[idx];
        clear_lane(lane);
        write_cfg(lane, cfg_word(row_mode[idx], row_repeat[idx], row_burst[idx],
                                 row_period[idx]));
        repeat (row_wait(idx)) @(negedge clock);
        read_status(lane, cnt, lock);
        if (row_mode[idx] == 2) begin
            check_nonzero($sformatf("%s first count", row_name[idx]), cnt);
            check_value($sformatf("%s first lock", row_name[idx]), 0, lock);
            repeat (CONT_SPACING) @(negedge clock);
            read_status(lane, cnt, lock);
            check_nonzero($sformatf("%s second count", row_name[idx]), cnt);
            check_value($sformatf("%s second lock", row_name[idx]), 0, lock);
        end else begin
            check_value($sformatf("%s count", row_name[idx]), expected_errors(idx), cnt);
            check_value($sformatf("%s lock", row_name[idx]), 1, lock);
            read_status(lane, cnt, lock);
            check_value($sformatf("%s count after clear", row_name[idx]), 0, cnt);
        end
    endtask

    // All four lanes run at once, each with its own schedule
    task automatic check_lane_independence();
        int longest;
        int lane;
        int cnt;
        int lock;
        longest = 0;
        for (int i = 0; i < pcs_rf_pkg::N_LANES; i++) begin
            clear_lane(row_lane[i]);
        end
        for (int i = 0; i < pcs_rf_pkg::N_LANES; i++) begin
            write_cfg(row_lane[i], cfg_word(row_mode[i], row_repeat[i], row_burst[i],
                                            row_period[i]));
            longest = (row_wait(i) > longest) ? row_wait(i) : longest;
        end
        repeat (longest) @(negedge clock);
        shuffle_lane_order();
        for (int k = 0; k < pcs_rf_pkg::N_LANES; k++) begin
            lane = lane_order[k];
            read_status(lane, cnt, lock);
            check_value($sformatf("parallel %s count", row_name[lane]),
                        expected_errors(lane), cnt);
            check_value($sformatf("parallel %s lock", row_name[lane]), 1, lock);
        end
    endtask

    // Lock was set before the disable and holds while nothing flows
    task automatic check_disabled_lane();
        int cnt;
        int lock;
        write_ctrl('0);
        write_cfg(row_lane[0], cfg_word(row_mode[0], row_repeat[0], row_burst[0],
                                        row_period[0]));
        repeat (row_wait(0)) @(negedge clock);
        read_status(row_lane[0], cnt, lock);
        check_value("disabled lane count", 0, cnt);
        check_value("disabled lane lock", 1, lock);
        write_cfg(row_lane[0], '0);
        write_ctrl(pcs_rf_pkg::data_t'(1));
    endtask

    task automatic expect_slverr(input logic write, input pcs_rf_pkg::addr_t addr);
        pcs_rf_pkg::data_t rdata;
        logic              slverr;
        apb_transfer(write, addr, '1, rdata, slverr);
        check_value($sformatf("pslverr at unmapped 0x%0h", addr), 1, int'(slverr));
    endtask

    task automatic check_address_errors();
        expect_slverr(1'b0, 8'h08);
        expect_slverr(1'b0, 8'h12);
        expect_slverr(1'b0, 8'h30);
        expect_slverr(1'b0, 8'hFC);
        expect_slverr(1'b1, 8'h30);
        expect_slverr(1'b1, 8'h0C);
        check_registers("after unmapped writes");
    endtask

    initial begin
        wait (table_ready);
        #(watchdog_ns);
        stop_on_error($sformatf("Watchdog expired after %0d ns with tests still running",
                                watchdog_ns));
    end

    initial begin
        int cnt;
        int lock;
        arst_n      = 1'b0;
        psel        = 1'b0;
        penable     = 1'b0;
        pwrite      = 1'b0;
        paddr       = '0;
        pwdata      = '0;
        table_ready = 1'b0;
        ctrl_shadow = '0;
        for (int lane = 0; lane < pcs_rf_pkg::N_LANES; lane++) begin
            cfg_shadow[lane] = '0;
        end
        void'($urandom(38703));
        load_table();
        watchdog_ns = 0;
        for (int i = 0; i < N_ROWS; i++) begin
            watchdog_ns += row_wait(i);
        end
        watchdog_ns = watchdog_ns * 2 * CLK_PERIOD_NS;
        table_ready = 1'b1;

        repeat (3) @(posedge clock);
        @(negedge clock);
        arst_n = 1'b1;

        // Zero out of reset, status included
        check_registers("reset");
        for (int lane = 0; lane < pcs_rf_pkg::N_LANES; lane++) begin
            read_status(lane, cnt, lock);
            check_value($sformatf("reset status count lane %0d", lane), 0, cnt);
            check_value($sformatf("reset status lock lane %0d", lane), 0, lock);
        end

        write_ctrl(pcs_rf_pkg::data_t'(1));
        shuffle_lane_order();
        for (int k = 0; k < pcs_rf_pkg::N_LANES; k++) begin
            write_cfg(lane_order[k], cfg_word(0, int'($urandom_range(0, 15)),
                                              int'($urandom_range(0, 1023)),
                                              int'($urandom_range(1, 1023))));
        end
        check_registers("readback");

        for (int i = 0; i < N_ROWS; i++) begin
            run_row(i);
        end
        check_lane_independence();
        check_disabled_lane();
        check_address_errors();

        $display("Regression passed");
        $finish;
    end

endmodule

// File: logic/pcs_rf_top.sv
`timescale 1ns/1ps

module pcs_rf_top (
    input  logic                i_clock,
    input  logic                i_arst_n,
    input  logic                i_psel,
    input  logic                i_penable,
    input  logic                i_pwrite,
    input  pcs_rf_pkg::addr_t   i_paddr,
    input  pcs_rf_pkg::data_t   i_pwdata,
    output pcs_rf_pkg::data_t   o_prdata,
    output logic                o_pready,
    output logic                o_pslverr
);

    logic                                               lane_enable;
    pcs_rf_pkg::mode_t      [pcs_rf_pkg::N_LANES-1:0]   lane_mode;
    pcs_rf_pkg::burst_t     [pcs_rf_pkg::N_LANES-1:0]   lane_burst;
    pcs_rf_pkg::period_t    [pcs_rf_pkg::N_LANES-1:0]   lane_period;
    pcs_rf_pkg::repeat_t    [pcs_rf_pkg::N_LANES-1:0]   lane_repeat;
    logic                   [pcs_rf_pkg::N_LANES-1:0]   lane_update;
    logic                   [pcs_rf_pkg::N_LANES-1:0]   lane_read_clear;
    pcs_rf_pkg::rd_sel_t                                rd_sel;
    logic                                               rd_capture;
    pcs_rf_pkg::data_t                                  ctrl_word;
    pcs_rf_pkg::data_t      [pcs_rf_pkg::N_LANES-1:0]   lane_cfg;
    pcs_rf_pkg::err_cnt_t   [pcs_rf_pkg::N_LANES-1:0]   lane_err_cnt;
    logic                   [pcs_rf_pkg::N_LANES-1:0]   lane_lock;

    rf_apb_slave u_rf_apb_slave (
        .i_clock       (i_clock),
        .i_arst_n      (i_arst_n),
        .i_psel        (i_psel),
        .i_penable     (i_penable),
        .i_pwrite      (i_pwrite),
        .i_paddr       (i_paddr),
        .i_pwdata      (i_pwdata),
        .o_pready      (o_pready),
        .o_pslverr     (o_pslverr),
        .o_lane_enable (lane_enable),
        .o_lane_mode   (lane_mode),
        .o_lane_burst  (lane_burst),
        .o_lane_period (lane_period),
        .o_lane_repeat (lane_repeat),
        .o_update      (lane_update),
        .o_read_clear  (lane_read_clear),
        .o_rd_sel      (rd_sel),
        .o_rd_capture  (rd_capture)
    );

    assign ctrl_word = pcs_rf_pkg::data_t'(lane_enable) << pcs_rf_pkg::CTRL_ENABLE_BIT;

    for (genvar g = 0; g < pcs_rf_pkg::N_LANES; g++) begin : g_lane
        // CFG readback packed from the stored fields
        assign lane_cfg[g] =
            (pcs_rf_pkg::data_t'(lane_mode[g])   << pcs_rf_pkg::CFG_MODE_LSB)   |
            (pcs_rf_pkg::data_t'(lane_repeat[g]) << pcs_rf_pkg::CFG_REPEAT_LSB) |
            (pcs_rf_pkg::data_t'(lane_burst[g])  << pcs_rf_pkg::CFG_BURST_LSB)  |
            (pcs_rf_pkg::data_t'(lane_period[g]) << pcs_rf_pkg::CFG_PERIOD_LSB);

        sh_breaker_lane u_sh_breaker_lane (
            .i_clock      (i_clock),
            .i_arst_n     (i_arst_n),
            .i_enable     (lane_enable),
            .i_update     (lane_update[g]),
            .i_mode       (lane_mode[g]),
            .i_burst      (lane_burst[g]),
            .i_period     (lane_period[g]),
            .i_repeat     (lane_repeat[g]),
            .i_read_clear (lane_read_clear[g]),
            .o_err_cnt    (lane_err_cnt[g]),
            .o_lock       (lane_lock[g])
        );
    end

    rf_read_mux u_rf_read_mux (
        .i_clock      (i_clock),
        .i_arst_n     (i_arst_n),
        .i_rd_sel     (rd_sel),
        .i_rd_capture (rd_capture),
        .i_ctrl       (ctrl_word),
        .i_lane_cfg   (lane_cfg),
        .i_err_cnt    (lane_err_cnt),
        .i_lock       (lane_lock),
        .o_prdata     (o_prdata)
    );

endmodule

// File: logic/rf_read_mux.sv
`timescale 1ns/1ps

module rf_read_mux (
    input  logic                                            i_clock,
    input  logic                                            i_arst_n,
    input  pcs_rf_pkg::rd_sel_t                             i_rd_sel,
    input  logic                                            i_rd_capture,
    input  pcs_rf_pkg::data_t                               i_ctrl,
    input  pcs_rf_pkg::data_t    [pcs_rf_pkg::N_LANES-1:0]  i_lane_cfg,
    input  pcs_rf_pkg::err_cnt_t [pcs_rf_pkg::N_LANES-1:0]  i_err_cnt,
    input  logic                 [pcs_rf_pkg::N_LANES-1:0]  i_lock,
    output pcs_rf_pkg::data_t                               o_prdata
);

    pcs_rf_pkg::rd_kind_t   rd_kind;
    pcs_rf_pkg::lane_id_t   rd_lane;
    pcs_rf_pkg::data_t      status_word;
    pcs_rf_pkg::data_t      sel_word;

    assign rd_kind = i_rd_sel[$bits(pcs_rf_pkg::rd_sel_t)-1 -: pcs_rf_pkg::NB_RD_KIND];
    assign rd_lane = i_rd_sel[pcs_rf_pkg::NB_LANE_ID-1:0];

    // Status word of the selected lane
    always_comb begin
        status_word = '0;
        status_word[pcs_rf_pkg::STATUS_ERR_LSB +: pcs_rf_pkg::NB_ERR_CNT] = i_err_cnt[rd_lane];
        status_word[pcs_rf_pkg::STATUS_LOCK_BIT] = i_lock[rd_lane];
    end

    always_comb begin
        case (rd_kind)
            pcs_rf_pkg::RD_CTRL: begin
                sel_word = i_ctrl;
            end
            pcs_rf_pkg::RD_CFG: begin
                sel_word = i_lane_cfg[rd_lane];
            end
            pcs_rf_pkg::RD_STATUS: begin
                sel_word = status_word;
            end
            default: begin
                sel_word = '0;
            end
        endcase
    end

    // Holds until the next read
    always_ff @(posedge i_clock or negedge i_arst_n) begin
        if (!i_arst_n) begin
            o_prdata <= '0;
        end else if (i_rd_capture) begin
            o_prdata <= sel_word;
        end
    end

endmodule

// File: logic/sh_breaker_lane.sv
`timescale 1ns/1ps

module sh_breaker_lane (
    input  logic                    i_clock,
    input  logic                    i_arst_n,
    input  logic                    i_enable,
    input  logic                    i_update,
    input  pcs_rf_pkg::mode_t       i_mode,
    input  pcs_rf_pkg::burst_t      i_burst,
    input  pcs_rf_pkg::period_t     i_period,
    input  pcs_rf_pkg::repeat_t     i_repeat,
    input  logic                    i_read_clear,
    output pcs_rf_pkg::err_cnt_t    o_err_cnt,
    output logic                    o_lock
);

    pcs_rf_pkg::payload_t       blk_cnt;
    pcs_rf_pkg::sh_t            tx_sh;
    pcs_rf_pkg::block_t         tx_block;
    pcs_rf_pkg::block_t         brk_block;
    pcs_rf_pkg::block_t         rx_block;
    pcs_rf_pkg::sh_t            rx_sh;
    logic                       brk_valid;
    logic                       rx_valid;
    pcs_rf_pkg::lane_state_t    state;
    pcs_rf_pkg::period_t        blk_idx;
    pcs_rf_pkg::repeat_t        rep_cnt;
    pcs_rf_pkg::period_t        burst_clip;
    logic                       period_end;
    logic                       break_now;
    logic                       sh_invalid;
    pcs_rf_pkg::lock_cnt_t      run_cnt;

    // Block source, headers alternate data and control
    assign tx_sh    = blk_cnt[0] ? pcs_rf_pkg::SH_CTRL : pcs_rf_pkg::SH_DATA;
    assign tx_block = {tx_sh, blk_cnt};

    always_ff @(posedge i_clock or negedge i_arst_n) begin
        if (!i_arst_n) begin
            blk_cnt <= '0;
        end else if (i_enable) begin
            blk_cnt <= blk_cnt + 1'b1;
        end
    end

    // Breaker schedule
    assign burst_clip = (i_burst > i_period) ? i_period : i_burst;
    assign period_end = (blk_idx == i_period - 1'b1);
    assign break_now  = (state == pcs_rf_pkg::BREAK_RUN) && (blk_idx < burst_clip);

    always_ff @(posedge i_clock or negedge i_arst_n) begin
        if (!i_arst_n) begin
            state   <= pcs_rf_pkg::IDLE;
            blk_idx <= '0;
            rep_cnt <= '0;
        end else if (i_update) begin
            blk_idx <= '0;
            rep_cnt <= '0;
            if (i_mode == pcs_rf_pkg::MODE_CONT ||
                (i_mode == pcs_rf_pkg::MODE_FIXED && i_repeat != '0)) begin
                state <= pcs_rf_pkg::BREAK_RUN;
            end else if (i_mode == pcs_rf_pkg::MODE_FIXED) begin
                state <= pcs_rf_pkg::BREAK_DONE;
            end else begin
                state <= pcs_rf_pkg::IDLE;
            end
        end else if (i_enable) begin
            case (state)
                pcs_rf_pkg::BREAK_RUN: begin
                    if (period_end) begin
                        blk_idx <= '0;
                        if (i_mode == pcs_rf_pkg::MODE_FIXED) begin
                            rep_cnt <= rep_cnt + 1'b1;
                            if (rep_cnt == i_repeat - 1'b1) begin
                                state <= pcs_rf_pkg::BREAK_DONE;
                            end
                        end
                    end else begin
                        blk_idx <= blk_idx + 1'b1;
                    end
                end
                // Idle and done hold
                default: ;
            endcase
        end
    end

    always_ff @(posedge i_clock or negedge i_arst_n) begin
        if (!i_arst_n) begin
            brk_valid <= 1'b0;
            rx_valid  <= 1'b0;
        end else begin
            brk_valid <= i_enable;
            rx_valid  <= brk_valid;
        end
    end

    always_ff @(posedge i_clock) begin
        brk_block <= tx_block;
        if (break_now) begin
            brk_block[pcs_rf_pkg::NB_CODED_BLOCK-1 -: pcs_rf_pkg::NB_SH] <=
                tx_sh ^ pcs_rf_pkg::SH_BREAK_MASK;
        end
        rx_block <= brk_block;
    end

    // Header checker
    assign rx_sh      = rx_block[pcs_rf_pkg::NB_CODED_BLOCK-1 -: pcs_rf_pkg::NB_SH];
    assign sh_invalid = rx_valid && (rx_sh[1] == rx_sh[0]);

    always_ff @(posedge i_clock or negedge i_arst_n) begin
        if (!i_arst_n) begin
            o_err_cnt <= '0;
        end else if (i_read_clear) begin
            o_err_cnt <= pcs_rf_pkg::err_cnt_t'(sh_invalid);
        end else if (sh_invalid && o_err_cnt != '1) begin
            o_err_cnt <= o_err_cnt + 1'b1;
        end
    end

    // Lock after a run of good headers
    always_ff @(posedge i_clock or negedge i_arst_n) begin
        if (!i_arst_n) begin
            o_lock  <= 1'b0;
            run_cnt <= '0;
        end else if (sh_invalid) begin
            o_lock  <= 1'b0;
            run_cnt <= '0;
        end else if (rx_valid && !o_lock) begin
            if (run_cnt == pcs_rf_pkg::LOCK_LAST) begin
                o_lock  <= 1'b1;
                run_cnt <= '0;
            end else begin
                run_cnt <= run_cnt + 1'b1;
            end
        end
    end

endmodule

// File: logic/rf_apb_slave.sv
`timescale 1ns/1ps

module rf_apb_slave (
    input  logic                                            i_clock,
    input  logic                                            i_arst_n,
    input  logic                                            i_psel,
    input  logic                                            i_penable,
    input  logic                                            i_pwrite,
    input  pcs_rf_pkg::addr_t                               i_paddr,
    input  pcs_rf_pkg::data_t                               i_pwdata,
    output logic                                            o_pready,
    output logic                                            o_pslverr,
    output logic                                            o_lane_enable,
    output pcs_rf_pkg::mode_t   [pcs_rf_pkg::N_LANES-1:0]   o_lane_mode,
    output pcs_rf_pkg::burst_t  [pcs_rf_pkg::N_LANES-1:0]   o_lane_burst,
    output pcs_rf_pkg::period_t [pcs_rf_pkg::N_LANES-1:0]   o_lane_period,
    output pcs_rf_pkg::repeat_t [pcs_rf_pkg::N_LANES-1:0]   o_lane_repeat,
    output logic                [pcs_rf_pkg::N_LANES-1:0]   o_update,
    output logic                [pcs_rf_pkg::N_LANES-1:0]   o_read_clear,
    output pcs_rf_pkg::rd_sel_t                             o_rd_sel,
    output logic                                            o_rd_capture
);

    logic                   access;
    logic                   rd_wait;
    logic                   wr_en;
    logic                   in_lanes;
    logic                   hit_ctrl;
    logic                   hit_cfg;
    logic                   hit_status;
    logic                   addr_err;
    pcs_rf_pkg::addr_t      lane_off;
    pcs_rf_pkg::addr_t      lane_num;
    pcs_rf_pkg::addr_t      lane_sub;
    pcs_rf_pkg::lane_id_t   lane_idx;
    pcs_rf_pkg::rd_kind_t   rd_kind;

    // Address decode
    assign lane_off = i_paddr - pcs_rf_pkg::ADDR_LANE_BASE;
    assign lane_num = lane_off / pcs_rf_pkg::LANE_STRIDE;
    assign lane_sub = lane_off % pcs_rf_pkg::LANE_STRIDE;
    assign lane_idx = lane_num[pcs_rf_pkg::NB_LANE_ID-1:0];

    assign in_lanes   = (i_paddr >= pcs_rf_pkg::ADDR_LANE_BASE) &&
                        (lane_num < pcs_rf_pkg::addr_t'(pcs_rf_pkg::N_LANES));
    assign hit_ctrl   = (i_paddr == pcs_rf_pkg::ADDR_CTRL);
    assign hit_cfg    = in_lanes && (lane_sub == pcs_rf_pkg::CFG_OFFSET);
    assign hit_status = in_lanes && (lane_sub == pcs_rf_pkg::STATUS_OFFSET);
    assign addr_err   = !(hit_ctrl || hit_cfg || hit_status);

    always_comb begin
        if (hit_ctrl) begin
            rd_kind = pcs_rf_pkg::RD_CTRL;
        end else if (hit_cfg) begin
            rd_kind = pcs_rf_pkg::RD_CFG;
        end else if (hit_status) begin
            rd_kind = pcs_rf_pkg::RD_STATUS;
        end else begin
            rd_kind = pcs_rf_pkg::RD_NONE;
        end
    end

    assign o_rd_sel = {rd_kind, lane_idx};

    // Writes finish at once, reads take one wait state
    assign access       = i_psel & i_penable;
    assign o_pready     = access & (i_pwrite | rd_wait);
    assign o_pslverr    = o_pready & addr_err;
    assign o_rd_capture = access & ~i_pwrite & ~rd_wait;
    assign wr_en        = o_pready & i_pwrite & ~addr_err;

    always_ff @(posedge i_clock or negedge i_arst_n) begin
        if (!i_arst_n) begin
            rd_wait <= 1'b0;
        end else if (o_rd_capture) begin
            rd_wait <= 1'b1;
        end else if (o_pready || !i_psel) begin
            rd_wait <= 1'b0;
        end
    end

    always_ff @(posedge i_clock or negedge i_arst_n) begin
        if (!i_arst_n) begin
            o_lane_enable <= 1'b0;
            o_lane_mode   <= '0;
            o_lane_burst  <= '0;
            o_lane_period <= '0;
            o_lane_repeat <= '0;
            o_update      <= '0;
            o_read_clear  <= '0;
        end else begin
            o_update     <= '0;
            o_read_clear <= '0;
            if (wr_en && hit_ctrl) begin
                o_lane_enable <= i_pwdata[pcs_rf_pkg::CTRL_ENABLE_BIT];
            end
            if (wr_en && hit_cfg) begin
                o_lane_mode[lane_idx]   <=
                    i_pwdata[pcs_rf_pkg::CFG_MODE_LSB +: pcs_rf_pkg::NB_MODE];
                o_lane_repeat[lane_idx] <=
                    i_pwdata[pcs_rf_pkg::CFG_REPEAT_LSB +: pcs_rf_pkg::NB_REPEAT_CNT];
                o_lane_burst[lane_idx]  <=
                    i_pwdata[pcs_rf_pkg::CFG_BURST_LSB +: pcs_rf_pkg::NB_BURST_CNT];
                o_lane_period[lane_idx] <=
                    i_pwdata[pcs_rf_pkg::CFG_PERIOD_LSB +: pcs_rf_pkg::NB_PERIOD_CNT];
                o_update[lane_idx]      <= 1'b1;
            end
            // Clear lands on the completing cycle of the read
            if (o_rd_capture && hit_status) begin
                o_read_clear[lane_idx] <= 1'b1;
            end
        end
    end

endmodule

// File: logic/pcs_rf_pkg.sv
package pcs_rf_pkg;

    localparam int N_LANES        = 4;
    localparam int NB_LANE_ID     = $clog2(N_LANES);
    localparam int NB_ADDR        = 8;
    localparam int NB_DATA        = 32;
    localparam int NB_CODED_BLOCK = 66;
    localparam int NB_SH          = 2;
    localparam int NB_MODE        = 2;
    localparam int NB_BURST_CNT   = 10;
    localparam int NB_PERIOD_CNT  = 10;
    localparam int NB_REPEAT_CNT  = 4;
    localparam int NB_ERR_CNT     = 16;
    localparam int LOCK_BLOCKS    = 64;
    localparam int NB_LOCK_CNT    = $clog2(LOCK_BLOCKS);
    localparam int NB_RD_KIND     = 2;

    typedef logic [NB_ADDR-1:0]                 addr_t;
    typedef logic [NB_DATA-1:0]                 data_t;
    typedef logic [NB_CODED_BLOCK-1:0]          block_t;
    typedef logic [NB_CODED_BLOCK-NB_SH-1:0]    payload_t;
    typedef logic [NB_SH-1:0]                   sh_t;
    typedef logic [NB_MODE-1:0]                 mode_t;
    typedef logic [NB_BURST_CNT-1:0]            burst_t;
    typedef logic [NB_PERIOD_CNT-1:0]           period_t;
    typedef logic [NB_REPEAT_CNT-1:0]           repeat_t;
    typedef logic [NB_ERR_CNT-1:0]              err_cnt_t;
    typedef logic [NB_LOCK_CNT-1:0]             lock_cnt_t;
    typedef logic [NB_LANE_ID-1:0]              lane_id_t;
    typedef logic [NB_RD_KIND-1:0]              rd_kind_t;
    // Read select is {kind, lane}
    typedef logic [NB_RD_KIND+NB_LANE_ID-1:0]   rd_sel_t;

    typedef enum logic [1:0] {
        IDLE,
        BREAK_RUN,
        BREAK_DONE
    } lane_state_t;

    localparam mode_t     MODE_OFF   = 2'd0;
    localparam mode_t     MODE_FIXED = 2'd1;
    localparam mode_t     MODE_CONT  = 2'd2;

    localparam sh_t       SH_DATA       = 2'b01;
    localparam sh_t       SH_CTRL       = 2'b10;
    // Flips 01 to 00 and 10 to 11
    localparam sh_t       SH_BREAK_MASK = 2'b01;

    localparam lock_cnt_t LOCK_LAST = lock_cnt_t'(LOCK_BLOCKS - 1);

    localparam rd_kind_t  RD_NONE   = 2'd0;
    localparam rd_kind_t  RD_CTRL   = 2'd1;
    localparam rd_kind_t  RD_CFG    = 2'd2;
    localparam rd_kind_t  RD_STATUS = 2'd3;

    localparam addr_t     ADDR_CTRL      = 8'h00;
    localparam addr_t     ADDR_LANE_BASE = 8'h10;
    localparam addr_t     LANE_STRIDE    = 8'h08;
    localparam addr_t     CFG_OFFSET     = 8'h00;
    localparam addr_t     STATUS_OFFSET  = 8'h04;

    localparam int CTRL_ENABLE_BIT = 0;
    localparam int CFG_MODE_LSB    = 0;
    localparam int CFG_REPEAT_LSB  = 4;
    localparam int CFG_BURST_LSB   = 8;
    localparam int CFG_PERIOD_LSB  = 18;
    localparam int STATUS_ERR_LSB  = 0;
    localparam int STATUS_LOCK_BIT = 16;

endpackage
